/* source/vcr_consts.svh */
/*
 * mesh router constants
 * port count, virtual channels, buffer depth and flit field widths
 */
`ifndef VCR_CONSTS_SVH
`define VCR_CONSTS_SVH

// router geometry
`define VCR_NUM_PORTS 5
`define VCR_NUM_VC 2

// slots per vc, also the credits held per downstream vc
`define VCR_VC_DEPTH 2
`define VCR_VC_ID_W 1

// flit fields
`define VCR_COORD_W 2
`define VCR_PAYLOAD_W 16

`endif

/* source/vcr_pkg.sv */
/*
 * mesh router package
 * port directions and the flit, link, credit and router id types
 */
`include "vcr_consts.svh"

package vcr_pkg;

  // value is the port index
  typedef enum logic [2:0] {
    dir_north = 3'd0,
    dir_east  = 3'd1,
    dir_south = 3'd2,
    dir_west  = 3'd3,
    dir_local = 3'd4
  } port_dir_e;

  typedef struct packed {
    logic [`VCR_COORD_W-1:0]   dst_x;
    logic [`VCR_COORD_W-1:0]   dst_y;
    logic [`VCR_PAYLOAD_W-1:0] payload;
  } flit_t;

  // one flit per cycle on a link, valid is a level
  typedef struct packed {
    logic                    valid;
    logic [`VCR_VC_ID_W-1:0] vc_id;
    flit_t                   flit;
  } link_t;

  // one pulse per freed slot
  typedef struct packed {
    logic                    valid;
    logic [`VCR_VC_ID_W-1:0] vc_id;
  } credit_t;

  typedef struct packed {
    logic [`VCR_COORD_W-1:0] x;
    logic [`VCR_COORD_W-1:0] y;
  } router_id_t;

endpackage

/* source/vcr_rr_arbiter.sv */
/*
 * round-robin arbiter
 * one-hot grant from the pointer onwards, pointer moves on accepted grants
 */
module vcr_rr_arbiter #(
  parameter int NumReq = 2
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [NumReq-1:0] req_i,
  input  logic              accept_i,
  output logic [NumReq-1:0] grant_oh_o
);

  localparam int PtrW = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [PtrW-1:0] ptr_q;
  // slot just past the current winner
  logic [PtrW-1:0] ptr_d;

  always_comb begin
    int   idx;
    logic found;
    grant_oh_o = '0;
    ptr_d      = ptr_q;
    found      = 1'b0;
    for (int i = 0; i < NumReq; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= NumReq) begin
        idx = idx - NumReq;
      end
      if (req_i[idx] && !found) begin
        found           = 1'b1;
        grant_oh_o[idx] = 1'b1;
        ptr_d           = (idx == NumReq - 1) ? '0 : PtrW'(idx + 1);
      end
    end
  end

  // a refused grant keeps the pointer, so it is offered again
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (accept_i && (|grant_oh_o)) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

/* source/vcr_input_port.sv */
/*
 * router input port
 * one flit FIFO per vc, XY route of every head flit and the credit
 * pulse returned upstream when a flit leaves
 */
`include "vcr_consts.svh"

module vcr_input_port import vcr_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  link_t                       data_i,
  input  router_id_t                  router_id_i,
  input  logic                        pop_i,
  input  logic      [`VCR_NUM_VC-1:0] pop_vc_oh_i,
  output logic      [`VCR_NUM_VC-1:0] head_v_o,
  output port_dir_e [`VCR_NUM_VC-1:0] head_dir_o,
  output flit_t     [`VCR_NUM_VC-1:0] head_flit_o,
  output credit_t                     credit_o
);

  localparam int Depth = `VCR_VC_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);
  localparam int VcIdW = `VCR_VC_ID_W;

  logic [VcIdW-1:0] pop_vc_id;
  credit_t          credit_q;

  // x first, then y; greater y is north
  function automatic port_dir_e xy_route(input flit_t flit, input router_id_t id);
    port_dir_e dir;
    if (flit.dst_x > id.x) begin
      dir = dir_east;
    end else if (flit.dst_x < id.x) begin
      dir = dir_west;
    end else if (flit.dst_y > id.y) begin
      dir = dir_north;
    end else if (flit.dst_y < id.y) begin
      dir = dir_south;
    end else begin
      dir = dir_local;
    end
    return dir;
  endfunction

  // ==============================
  // per vc FIFOs
  // ==============================
  for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_vc
    flit_t           mem [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            push;
    logic            pop;

    // upstream only sends with a credit in hand, so no full check
    assign push = data_i.valid && (data_i.vc_id == VcIdW'(v));
    assign pop  = pop_i && pop_vc_oh_i[v];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem[wr_ptr_q] <= data_i.flit;
      end
    end

    assign head_v_o[v]    = (count_q != '0);
    assign head_flit_o[v] = mem[rd_ptr_q];
    assign head_dir_o[v]  = xy_route(mem[rd_ptr_q], router_id_i);
  end

  // ==============================
  // upstream credit
  // ==============================
  always_comb begin
    pop_vc_id = '0;
    for (int v = 0; v < `VCR_NUM_VC; v++) begin
      if (pop_vc_oh_i[v]) begin
        pop_vc_id = VcIdW'(v);
      end
    end
  end

  // lines up with the crossbar register, same cycle as data_o
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= '0;
    end else begin
      credit_q.valid <= pop_i;
      credit_q.vc_id <= pop_vc_id;
    end
  end

  assign credit_o = credit_q;

endmodule

/* source/vcr_credit_tracker.sv */
/*
 * output credit tracker
 * free slot count per downstream vc of one output port
 */
`include "vcr_consts.svh"

module vcr_credit_tracker import vcr_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  credit_t                     credit_i,
  input  logic                        consume_i,
  input  logic [`VCR_VC_ID_W-1:0]     consume_vc_i,
  output logic [`VCR_NUM_VC-1:0]      vc_avail_o
);

  localparam int CntW  = $clog2(`VCR_VC_DEPTH + 1);
  localparam int VcIdW = `VCR_VC_ID_W;

  for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_cnt
    logic [CntW-1:0] count_q;
    logic            inc;
    logic            dec;

    assign inc = credit_i.valid && (credit_i.vc_id == VcIdW'(v));
    assign dec = consume_i && (consume_vc_i == VcIdW'(v));

    // count stays in 0..depth; a returning credit and a send cancel
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        count_q <= CntW'(`VCR_VC_DEPTH);
      end else if (inc && !dec) begin
        count_q <= count_q + 1'b1;
      end else if (dec && !inc) begin
        count_q <= count_q - 1'b1;
      end
    end

    assign vc_avail_o[v] = (count_q != '0);
  end

endmodule

/* source/vcr_switch_alloc.sv */
/*
 * switch allocator
 * local arbitration picks a vc per input, global arbitration picks an
 * input per output, then the lowest free downstream vc is assigned
 */
`include "vcr_consts.svh"

module vcr_switch_alloc import vcr_pkg::*; (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  logic      [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]   head_v_i,
  input  port_dir_e [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]   head_dir_i,
  input  logic      [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]   vc_avail_i,
  output logic      [`VCR_NUM_PORTS-1:0]                    pop_o,
  output logic      [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]   pop_vc_oh_o,
  output logic      [`VCR_NUM_PORTS-1:0]                    grant_v_o,
  output logic      [`VCR_NUM_PORTS-1:0][`VCR_NUM_PORTS-1:0] grant_in_oh_o,
  output logic      [`VCR_NUM_PORTS-1:0][`VCR_VC_ID_W-1:0]  grant_vc_o
);

  localparam int NumPorts = `VCR_NUM_PORTS;
  localparam int NumVc    = `VCR_NUM_VC;
  localparam int VcIdW    = `VCR_VC_ID_W;

  logic      [NumPorts-1:0]            out_ok;
  logic      [NumPorts-1:0][NumVc-1:0] local_req;
  logic      [NumPorts-1:0][NumVc-1:0] local_gnt_oh;
  logic      [NumPorts-1:0]            local_v;
  port_dir_e [NumPorts-1:0]            local_dir;
  // indexed [output][input]
  logic      [NumPorts-1:0][NumPorts-1:0] global_req;

  // ==============================
  // local step, one vc per input
  // ==============================
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      out_ok[o] = |vc_avail_i[o];
    end
    // a head only competes if its output has somewhere to go
    for (int i = 0; i < NumPorts; i++) begin
      for (int v = 0; v < NumVc; v++) begin
        local_req[i][v] = head_v_i[i][v] && out_ok[head_dir_i[i][v]];
      end
    end
  end

  for (genvar i = 0; i < NumPorts; i++) begin : gen_local
    vcr_rr_arbiter #(
      .NumReq     (NumVc)
    ) u_local_arb (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_i      (local_req[i]),
      .accept_i   (pop_o[i]),
      .grant_oh_o (local_gnt_oh[i])
    );
  end

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      local_v[i]   = |local_gnt_oh[i];
      local_dir[i] = dir_north;
      for (int v = 0; v < NumVc; v++) begin
        if (local_gnt_oh[i][v]) begin
          local_dir[i] = head_dir_i[i][v];
        end
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        global_req[o][i] = local_v[i] && (local_dir[i] == port_dir_e'(o));
      end
    end
  end

  // ==============================
  // global step, one input per output
  // ==============================
  for (genvar o = 0; o < NumPorts; o++) begin : gen_global
    vcr_rr_arbiter #(
      .NumReq     (NumPorts)
    ) u_global_arb (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_i      (global_req[o]),
      .accept_i   (grant_v_o[o]),
      .grant_oh_o (grant_in_oh_o[o])
    );
  end

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      grant_v_o[o]  = |grant_in_oh_o[o];
      // lowest indexed vc with credit wins
      grant_vc_o[o] = '0;
      for (int v = NumVc - 1; v >= 0; v--) begin
        if (vc_avail_i[o][v]) begin
          grant_vc_o[o] = VcIdW'(v);
        end
      end
    end
    for (int i = 0; i < NumPorts; i++) begin
      pop_o[i] = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        pop_o[i] = pop_o[i] | grant_in_oh_o[o][i];
      end
      pop_vc_oh_o[i] = pop_o[i] ? local_gnt_oh[i] : '0;
    end
  end

endmodule

/* source/vcr_crossbar.sv */
/*
 * router crossbar
 * allocation to traversal register and the output multiplexers
 */
`include "vcr_consts.svh"

module vcr_crossbar import vcr_pkg::*; (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  flit_t [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]        head_flit_i,
  input  logic  [`VCR_NUM_PORTS-1:0][`VCR_NUM_VC-1:0]        pop_vc_oh_i,
  input  logic  [`VCR_NUM_PORTS-1:0]                         grant_v_i,
  input  logic  [`VCR_NUM_PORTS-1:0][`VCR_NUM_PORTS-1:0]     grant_in_oh_i,
  input  logic  [`VCR_NUM_PORTS-1:0][`VCR_VC_ID_W-1:0]       grant_vc_i,
  output link_t [`VCR_NUM_PORTS-1:0]                         data_o
);

  localparam int NumPorts = `VCR_NUM_PORTS;
  localparam int NumVc    = `VCR_NUM_VC;

  flit_t [NumPorts-1:0]                    sel_flit;
  logic  [NumPorts-1:0]                    valid_q;
  logic  [NumPorts-1:0][`VCR_VC_ID_W-1:0]  vc_q;
  flit_t [NumPorts-1:0]                    flit_q;

  // granted input, then the vc its local arbiter picked
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      sel_flit[o] = '0;
      for (int i = 0; i < NumPorts; i++) begin
        for (int v = 0; v < NumVc; v++) begin
          if (grant_in_oh_i[o][i] && pop_vc_oh_i[i][v]) begin
            sel_flit[o] = head_flit_i[i][v];
          end
        end
      end
    end
  end

  // ==============================
  // traversal stage
  // ==============================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= grant_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (grant_v_i[o]) begin
        vc_q[o]   <= grant_vc_i[o];
        flit_q[o] <= sel_flit[o];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    assign data_o[o].valid = valid_q[o];
    assign data_o[o].vc_id = vc_q[o];
    assign data_o[o].flit  = flit_q[o];
  end

endmodule

/* source/vcr_router.sv */
/*
 * five port mesh router with virtual channels
 * input FIFOs, switch allocation, credit tracking and crossbar
 */
`include "vcr_consts.svh"

module vcr_router import vcr_pkg::*; (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  router_id_t                     router_id_i,
  input  link_t   [`VCR_NUM_PORTS-1:0]   data_i,
  output credit_t [`VCR_NUM_PORTS-1:0]   credit_o,
  input  credit_t [`VCR_NUM_PORTS-1:0]   credit_i,
  output link_t   [`VCR_NUM_PORTS-1:0]   data_o
);

  localparam int NumPorts = `VCR_NUM_PORTS;
  localparam int NumVc    = `VCR_NUM_VC;

  logic      [NumPorts-1:0][NumVc-1:0]             head_v;
  port_dir_e [NumPorts-1:0][NumVc-1:0]             head_dir;
  flit_t     [NumPorts-1:0][NumVc-1:0]             head_flit;
  logic      [NumPorts-1:0]                        pop;
  logic      [NumPorts-1:0][NumVc-1:0]             pop_vc_oh;
  logic      [NumPorts-1:0][NumVc-1:0]             vc_avail;
  logic      [NumPorts-1:0]                        grant_v;
  logic      [NumPorts-1:0][NumPorts-1:0]          grant_in_oh;
  logic      [NumPorts-1:0][`VCR_VC_ID_W-1:0]      grant_vc;

  // ==============================
  // input ports
  // ==============================
  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    vcr_input_port u_input_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .data_i      (data_i[i]),
      .router_id_i (router_id_i),
      .pop_i       (pop[i]),
      .pop_vc_oh_i (pop_vc_oh[i]),
      .head_v_o    (head_v[i]),
      .head_dir_o  (head_dir[i]),
      .head_flit_o (head_flit[i]),
      .credit_o    (credit_o[i])
    );
  end

  // ==============================
  // output credit trackers
  // ==============================
  // every grant is a send, so it consumes one credit
  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    vcr_credit_tracker u_credit_tracker (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .credit_i     (credit_i[o]),
      .consume_i    (grant_v[o]),
      .consume_vc_i (grant_vc[o]),
      .vc_avail_o   (vc_avail[o])
    );
  end

  vcr_switch_alloc u_switch_alloc (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .head_v_i      (head_v),
    .head_dir_i    (head_dir),
    .vc_avail_i    (vc_avail),
    .pop_o         (pop),
    .pop_vc_oh_o   (pop_vc_oh),
    .grant_v_o     (grant_v),
    .grant_in_oh_o (grant_in_oh),
    .grant_vc_o    (grant_vc)
  );

  vcr_crossbar u_crossbar (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .head_flit_i   (head_flit),
    .pop_vc_oh_i   (pop_vc_oh),
    .grant_v_i     (grant_v),
    .grant_in_oh_i (grant_in_oh),
    .grant_vc_i    (grant_vc),
    .data_o        (data_o)
  );

endmodule

/* verification/vcr_router_asserts.sv */
/*
 * router assertions
 * credit use on outputs, credit pulses on inputs, quiet outputs in reset
 */
`include "vcr_consts.svh"

module vcr_router_asserts import vcr_pkg::*; (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  link_t   [`VCR_NUM_PORTS-1:0]   in_link_i,
  input  credit_t [`VCR_NUM_PORTS-1:0]   in_credit_i,
  input  link_t   [`VCR_NUM_PORTS-1:0]   out_link_i,
  input  credit_t [`VCR_NUM_PORTS-1:0]   out_credit_i
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int VcIdW = `VCR_VC_ID_W;
  localparam int CntW  = $clog2(`VCR_VC_DEPTH + 1);

  for (genvar p = 0; p < `VCR_NUM_PORTS; p++) begin : gen_port
    for (genvar v = 0; v < `VCR_NUM_VC; v++) begin : gen_vc
      // flits taken in on this vc and not yet credited back
      logic [3:0]      held_q;
      logic            arrive;
      logic            leave;
      // free downstream slots, seen only from the output link
      logic [CntW-1:0] free_q;
      logic            send;
      logic            refill;

      assign arrive = in_link_i[p].valid && (in_link_i[p].vc_id == VcIdW'(v));
      assign leave  = in_credit_i[p].valid && (in_credit_i[p].vc_id == VcIdW'(v));
      assign send   = out_link_i[p].valid && (out_link_i[p].vc_id == VcIdW'(v));
      assign refill = out_credit_i[p].valid && (out_credit_i[p].vc_id == VcIdW'(v));

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          held_q <= '0;
        end else if (arrive && !leave) begin
          held_q <= held_q + 1'b1;
        end else if (leave && !arrive) begin
          held_q <= held_q - 1'b1;
        end
      end

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          free_q <= CntW'(`VCR_VC_DEPTH);
        end else if (send && !refill) begin
          free_q <= free_q - 1'b1;
        end else if (refill && !send) begin
          free_q <= free_q + 1'b1;
        end
      end

      a_credit_after_flit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        leave |-> (held_q != '0))
        else $error("credit pulse on input %0d vc %0d with no flit taken in", p, v);

      a_send_with_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        send |-> (free_q != '0))
        else $error("output %0d sent on vc %0d with zero credit", p, v);
    end

    a_quiet_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |-> (!out_link_i[p].valid && !in_credit_i[p].valid))
      else $error("port %0d active while in reset", p);
  end

endmodule

bind vcr_router vcr_router_asserts u_vcr_router_asserts (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .in_link_i    (data_i),
  .in_credit_i  (credit_o),
  .out_link_i   (data_o),
  .out_credit_i (credit_i)
);

/* verification/tb_vcr_router.sv */
/*
 * testbench for the five port mesh router
 * credit-counting upstream senders, a downstream credit model that can
 * stall, an XY reference and a scoreboard per output
 */
`include "vcr_consts.svh"

module tb_vcr_router import vcr_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumPorts    = `VCR_NUM_PORTS;
  localparam int NumVc       = `VCR_NUM_VC;
  localparam int Depth       = `VCR_VC_DEPTH;
  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 16;
  localparam int RandFlits   = 200;
  localparam int StallFlits  = 12;
  localparam int LocalFlits  = 8;
  localparam int TotalFlits  = 1 + RandFlits + StallFlits + 4 * LocalFlits;
  localparam int StallHold   = 40;
  localparam int DrainLimit  = 2000;
  localparam int MaxFlits    = 512;
  // worst case cycles per flit plus the fixed phases
  localparam int TimeoutNs   = (TotalFlits * 24 + StallHold + 600) * ClkPeriod;
  localparam router_id_t RouterId = '{x: `VCR_COORD_W'(1), y: `VCR_COORD_W'(1)};

  logic                   clk;
  logic                   arst_n;
  link_t   [NumPorts-1:0] data_i;
  credit_t [NumPorts-1:0] credit_o;
  credit_t [NumPorts-1:0] credit_i;
  link_t   [NumPorts-1:0] data_o;

  int        seed;
  int        err_value;
  int        err_other;
  int        up_credit [NumPorts][NumVc];
  int        held [NumPorts][NumVc];
  // free downstream slots per output vc as of the last clock edge
  int        dn_credit [NumPorts][NumVc];
  bit        stall [NumPorts];
  int        n_sent;
  int        n_recv;
  int        recv_cnt [NumPorts];
  port_dir_e exp_port [MaxFlits];
  flit_t     exp_flit [MaxFlits];
  int        exp_src [MaxFlits];
  bit        delivered [MaxFlits];

  vcr_router u_vcr_router (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .router_id_i (RouterId),
    .data_i      (data_i),
    .credit_o    (credit_o),
    .credit_i    (credit_i),
    .data_o      (data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ==============================
  // reference and checks
  // ==============================
  // dimension order, x before y, north is the larger y
  function automatic port_dir_e expected_port(input flit_t f);
    int        dx;
    int        dy;
    port_dir_e dir;
    dx = int'(f.dst_x) - int'(RouterId.x);
    dy = int'(f.dst_y) - int'(RouterId.y);
    if (dx > 0) begin
      dir = dir_east;
    end else if (dx < 0) begin
      dir = dir_west;
    end else if (dy > 0) begin
      dir = dir_north;
    end else if (dy < 0) begin
      dir = dir_south;
    end else begin
      dir = dir_local;
    end
    return dir;
  endfunction

  // lowest downstream vc that still has a free slot
  function automatic int lowest_credit_vc(input int o);
    int pick;
    pick = -1;
    for (int v = NumVc - 1; v >= 0; v--) begin
      if (dn_credit[o][v] > 0) begin
        pick = v;
      end
    end
    return pick;
  endfunction

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // fields only matter while valid is high
  task automatic check_link(input string what, input link_t got, input link_t exp);
    if ((got.valid !== exp.valid) ||
        (exp.valid && ((got.vc_id !== exp.vc_id) || (got.flit !== exp.flit)))) begin
      err_value++;
      $display("CHECK FAILED at time %0t: %s, got valid %b vc %0d flit %h",
               $time, what, got.valid, got.vc_id, got.flit);
      $display("  expected valid %b vc %0d flit %h", exp.valid, exp.vc_id, exp.flit);
    end
  endtask

  task automatic check_credit(input string what, input credit_t got, input credit_t exp);
    if ((got.valid !== exp.valid) || (exp.valid && (got.vc_id !== exp.vc_id))) begin
      err_value++;
      $display("CHECK FAILED at time %0t: %s, got credit %b vc %0d, expected %b vc %0d",
               $time, what, got.valid, got.vc_id, exp.valid, exp.vc_id);
    end
  endtask

  task automatic check_quiet(input string what);
    for (int p = 0; p < NumPorts; p++) begin
      check_link($sformatf("%s, data_o[%0d]", what, p), data_o[p], '0);
      check_credit($sformatf("%s, credit_o[%0d]", what, p), credit_o[p], '0);
    end
  endtask

  // ==============================
  // upstream and downstream models
  // ==============================
  task automatic absorb_credits();
    int v;
    for (int p = 0; p < NumPorts; p++) begin
      if (credit_o[p].valid) begin
        v = int'(credit_o[p].vc_id);
        if (up_credit[p][v] >= Depth) begin
          err_other++;
          $display("ERROR at time %0t: credit pulse on input %0d vc %0d with no flit held",
                   $time, p, v);
        end else begin
          up_credit[p][v]++;
        end
      end
    end
  endtask

  // one credit per output and cycle, returned after a random wait
  task automatic return_credits();
    int first;
    int v;
    for (int o = 0; o < NumPorts; o++) begin
      credit_i[o] = '0;
      if (!stall[o] && (rand_below(2) != 0)) begin
        first = rand_below(NumVc);
        for (int k = 0; k < NumVc; k++) begin
          v = (first + k) % NumVc;
          if (!credit_i[o].valid && (held[o][v] > 0)) begin
            held[o][v]--;
            credit_i[o].valid = 1'b1;
            credit_i[o].vc_id = `VCR_VC_ID_W'(v);
          end
        end
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    absorb_credits();
    return_credits();
    for (int p = 0; p < NumPorts; p++) begin
      data_i[p] = '0;
    end
  endtask

  function automatic int free_vc(input int port, input int first);
    int vc;
    int pick;
    pick = -1;
    for (int k = 0; k < NumVc; k++) begin
      vc = (first + k) % NumVc;
      if ((pick < 0) && (up_credit[port][vc] > 0)) begin
        pick = vc;
      end
    end
    return pick;
  endfunction

  // payload is the sequence number, so every flit is unique
  task automatic send_flit(input int port, input int vc, input int dst_x, input int dst_y);
    flit_t f;
    f.dst_x             = `VCR_COORD_W'(dst_x);
    f.dst_y             = `VCR_COORD_W'(dst_y);
    f.payload           = `VCR_PAYLOAD_W'(n_sent);
    exp_flit[n_sent]    = f;
    exp_port[n_sent]    = expected_port(f);
    exp_src[n_sent]     = port;
    delivered[n_sent]   = 1'b0;
    n_sent++;
    up_credit[port][vc]--;
    data_i[port].valid  = 1'b1;
    data_i[port].vc_id  = `VCR_VC_ID_W'(vc);
    data_i[port].flit   = f;
  endtask

  // ==============================
  // scoreboard
  // ==============================
  task automatic record_arrival(input int o, input link_t lnk);
    int    seq;
    int    exp_vc;
    link_t exp;
    seq    = int'(lnk.flit.payload);
    exp_vc = lowest_credit_vc(o);
    held[o][int'(lnk.vc_id)]++;
    if (held[o][int'(lnk.vc_id)] > Depth) begin
      err_other++;
      $display("ERROR at time %0t: output %0d overran the depth of downstream vc %0d",
               $time, o, lnk.vc_id);
    end
    if (exp_vc < 0) begin
      err_other++;
      $display("ERROR at time %0t: output %0d sent with no downstream credit left",
               $time, o);
      exp_vc = 0;
    end
    if ((seq >= n_sent) || delivered[seq]) begin
      err_other++;
      $display("ERROR at time %0t: output %0d sent flit %0d that was not pending",
               $time, o, seq);
    end else begin
      delivered[seq] = 1'b1;
      n_recv++;
      recv_cnt[o]++;
      if (o != int'(exp_port[seq])) begin
        err_value++;
        $display("CHECK FAILED at time %0t: flit %0d left on output %0d, expected %0d",
                 $time, seq, o, int'(exp_port[seq]));
      end
      exp.valid = 1'b1;
      exp.vc_id = `VCR_VC_ID_W'(exp_vc);
      exp.flit  = exp_flit[seq];
      check_link($sformatf("flit %0d on output %0d", seq, o), lnk, exp);
    end
  endtask

  // sample a little after the edge, where data_o is settled
  always @(posedge clk) begin
    #1;
    if (arst_n) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (data_o[o].valid) begin
          record_arrival(o, data_o[o]);
          dn_credit[o][int'(data_o[o].vc_id)]--;
        end
        // a credit taken at this edge only counts for the next grant
        if (credit_i[o].valid) begin
          dn_credit[o][int'(credit_i[o].vc_id)]++;
        end
      end
    end
  end

  task automatic drain(input string what);
    int cycles;
    cycles = 0;
    while ((n_recv < n_sent) && (cycles < DrainLimit)) begin
      tick();
      cycles++;
    end
    if (n_recv < n_sent) begin
      err_other++;
      $display("ERROR at time %0t: %0d flits never left the router during %s",
               $time, n_sent - n_recv, what);
    end
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic latency_test();
    link_t   exp_lnk;
    credit_t exp_cr;
    tick();
    send_flit(int'(dir_west), 1, 1, 0);
    exp_lnk.valid = 1'b1;
    exp_lnk.vc_id = '0;
    exp_lnk.flit  = exp_flit[n_sent - 1];
    exp_cr.valid  = 1'b1;
    exp_cr.vc_id  = `VCR_VC_ID_W'(1);
    tick();
    check_quiet("one edge after the single flit");
    tick();
    check_link("single flit on south", data_o[int'(dir_south)], exp_lnk);
    check_credit("single flit credit on west", credit_o[int'(dir_west)], exp_cr);
  endtask

  task automatic random_traffic();
    int count;
    int vc;
    count = 0;
    while (count < RandFlits) begin
      tick();
      for (int p = 0; p < NumPorts; p++) begin
        if ((count < RandFlits) && (rand_below(2) != 0)) begin
          vc = free_vc(p, rand_below(NumVc));
          if (vc >= 0) begin
            send_flit(p, vc, rand_below(1 << `VCR_COORD_W), rand_below(1 << `VCR_COORD_W));
            count++;
          end
        end
      end
    end
  endtask

  task automatic stall_test();
    int east;
    int start_cnt;
    int sent;
    int vc;
    east = int'(dir_east);
    // let east hand back what it holds, then block it
    while ((held[east][0] + held[east][NumVc - 1]) > 0) begin
      tick();
    end
    stall[east] = 1'b1;
    start_cnt   = recv_cnt[east];
    sent        = 0;
    while (sent < StallFlits) begin
      tick();
      for (int p = 0; p < NumPorts; p++) begin
        vc = free_vc(p, 0);
        if ((p != east) && (sent < StallFlits) && (vc >= 0)) begin
          send_flit(p, vc, 3, rand_below(1 << `VCR_COORD_W));
          sent++;
        end
      end
    end
    repeat (StallHold) tick();
    if ((recv_cnt[east] - start_cnt) > NumVc * Depth) begin
      err_other++;
      $display("ERROR at time %0t: stalled east output sent %0d flits without credit",
               $time, recv_cnt[east] - start_cnt);
    end
    stall[east] = 1'b0;
    drain("the east stall");
  endtask

  task automatic local_test();
    int first_seq;
    int cnt [4];
    int missing;
    int vc;
    first_seq = n_sent;
    for (int p = 0; p < 4; p++) begin
      cnt[p] = 0;
    end
    while ((cnt[0] + cnt[1] + cnt[2] + cnt[3]) < 4 * LocalFlits) begin
      tick();
      for (int p = 0; p < 4; p++) begin
        vc = free_vc(p, rand_below(NumVc));
        if ((cnt[p] < LocalFlits) && (vc >= 0)) begin
          send_flit(p, vc, 1, 1);
          cnt[p]++;
        end
      end
    end
    drain("local port contention");
    for (int p = 0; p < 4; p++) begin
      missing = 0;
      for (int s = first_seq; s < n_sent; s++) begin
        if ((exp_src[s] == p) && !delivered[s]) begin
          missing++;
        end
      end
      if (missing != 0) begin
        err_other++;
        $display("ERROR at time %0t: input %0d still waits with %0d flits for local",
                 $time, p, missing);
      end
    end
  endtask

  initial begin
    seed      = 15555;
    err_value = 0;
    err_other = 0;
    n_sent    = 0;
    n_recv    = 0;
    for (int p = 0; p < NumPorts; p++) begin
      stall[p]    = 1'b0;
      recv_cnt[p] = 0;
      for (int v = 0; v < NumVc; v++) begin
        up_credit[p][v] = Depth;
        held[p][v]      = 0;
        dn_credit[p][v] = Depth;
      end
    end
    data_i   = '0;
    credit_i = '0;
    arst_n   = 1'b1;
    #1;
    arst_n = 1'b0;
    for (int c = 0; c < ResetCycles; c++) begin
      tick();
      check_quiet("in reset");
    end
    arst_n = 1'b1;
    repeat (8) begin
      tick();
      check_quiet("idle after reset");
    end

    latency_test();
    drain("the single flit");
    random_traffic();
    drain("random traffic");
    stall_test();
    local_test();

    // every accepted flit owes exactly one credit upstream
    repeat (4) tick();
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVc; v++) begin
        if (up_credit[p][v] != Depth) begin
          err_other++;
          $display("ERROR at time %0t: input %0d vc %0d got back %0d of %0d credits",
                   $time, p, v, up_credit[p][v], Depth);
        end
      end
    end

    $display("summary: %0d flits, %0d value errors, %0d other errors",
             n_sent, err_value, err_other);
    if ((err_value == 0) && (err_other == 0)) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("ERROR at time %0t: watchdog expired, the run did not finish in %0d ns",
             $time, TimeoutNs);
    $display("summary: %0d flits, %0d value errors, %0d other errors",
             n_sent, err_value, err_other + 1);
    $display("Checks failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+source
source/vcr_pkg.sv
source/vcr_rr_arbiter.sv
source/vcr_input_port.sv
source/vcr_credit_tracker.sv
source/vcr_switch_alloc.sv
source/vcr_crossbar.sv
source/vcr_router.sv
verification/vcr_router_asserts.sv
verification/tb_vcr_router.sv

/* run_sim.sh */
#!/bin/sh
# build the router testbench with Verilator, run it and check the log

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
  -f sources.f \
  --top-module tb_vcr_router \
  -Mdir "$OBJ_DIR" -o vtb_vcr_router
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/vtb_vcr_router" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
